// File: common/imuldiv_pkg.sv
// ----------------------------------------------------------------------
// shared types of the multiply/divide unit: widths, function codes,
// request struct, unit selector and step counter
// ----------------------------------------------------------------------
package imuldiv_pkg;

  // operand width, one machine word
  localparam int xlen = 32;

  typedef logic [xlen-1:0] operand_t;

  // divides: remainder in the upper half, quotient in the lower half
  // multiply: full signed product
  typedef logic [2*xlen-1:0] result_t;

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_e;

  // one request as it sits in the steer register
  typedef struct packed {
    muldiv_fn_e fn;
    operand_t   a;
    operand_t   b;
  } muldiv_req_t;

  // entry type of the response order queue
  typedef enum logic {
    unit_mul = 1'b0,
    unit_div = 1'b1
  } unit_sel_e;

  // wide enough for xlen steps
  typedef logic [5:0] step_count_t;

endpackage

// File: common/muldiv_req_if.sv
// ----------------------------------------------------------------------
// request channel from the input side to one arithmetic unit
// ----------------------------------------------------------------------
`timescale 1ns/100ps

interface muldiv_req_if;
  import imuldiv_pkg::*;

  // valid/ready handshake, payload stable while val is high
  logic       val;
  logic       rdy;
  muldiv_fn_e fn;
  operand_t   a;
  operand_t   b;

  // input side
  modport sender (
    output val,
    output fn,
    output a,
    output b,
    input  rdy
  );

  // multiplier or divider
  modport unit (
    input  val,
    input  fn,
    input  a,
    input  b,
    output rdy
  );

endinterface

// File: src/muldiv_req_steer.sv
// ----------------------------------------------------------------------
// input side: one request register, unit decode, order queue push
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module muldiv_req_steer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  imuldiv_pkg::muldiv_fn_e req_fn,
  input  imuldiv_pkg::operand_t   req_a,
  input  imuldiv_pkg::operand_t   req_b,
  muldiv_req_if.sender            mul_req,
  muldiv_req_if.sender            div_req,
  output logic                    order_push,
  output imuldiv_pkg::unit_sel_e  order_unit,
  input  logic                    order_full
);
  import imuldiv_pkg::*;

  muldiv_req_t req_q;
  logic        req_q_val;
  unit_sel_e   unit;
  logic        fire;

  // multiply to the multiplier, both divides to the divider
  assign unit = (req_q.fn == fn_mul) ? unit_mul : unit_div;

  // only the selected unit sees val
  // order_full cannot rise while a request waits here, so val stays up
  assign mul_req.val = req_q_val && !order_full && (unit == unit_mul);
  assign div_req.val = req_q_val && !order_full && (unit == unit_div);

  assign mul_req.fn = req_q.fn;
  assign mul_req.a  = req_q.a;
  assign mul_req.b  = req_q.b;
  assign div_req.fn = req_q.fn;
  assign div_req.a  = req_q.a;
  assign div_req.b  = req_q.b;

  // register empties on the unit transfer
  assign fire = (mul_req.val && mul_req.rdy) || (div_req.val && div_req.rdy);

  // accept when empty or emptying this cycle
  assign req_rdy = !req_q_val || fire;

  // unit is recorded in the order queue on the same edge
  assign order_push = fire;
  assign order_unit = unit;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q_val <= 1'b0;
    end else if (req_val && req_rdy) begin
      req_q_val <= 1'b1;
    end else if (fire) begin
      req_q_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      req_q.fn <= req_fn;
      req_q.a  <= req_a;
      req_q.b  <= req_b;
    end
  end

endmodule

// File: int_div/int_div_ctrl.sv
// ----------------------------------------------------------------------
// divider control: idle, calc, sign, done FSM and step counter
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sign_en
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_sign,
    st_done
  } state_e;

  // one shift-subtract step per operand bit
  localparam step_count_t last_step = step_count_t'(xlen - 1);

  state_e      state;
  state_e      state_next;
  step_count_t count;
  logic        accept;

  assign accept = req_val && req_rdy;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (accept) state_next = st_calc;
      st_calc: if (count == last_step) state_next = st_sign;
      st_sign: state_next = st_done;
      // hold the result until the response transfer
      st_done: if (resp_rdy) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      state <= state_next;
      if (state == st_calc) begin
        count <= count + step_count_t'(1);
      end else begin
        count <= '0;
      end
    end
  end

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // load on accept, then step for the whole calc phase
  assign a_en      = accept || (state == st_calc);
  assign b_en      = accept;
  assign a_mux_sel = (state == st_calc);
  assign sign_en   = (state == st_sign);

endmodule

// File: int_div/int_div_dpath.sv
// ----------------------------------------------------------------------
// divider datapath: remainder/quotient register, divisor register,
// restoring shift-subtract step and final sign correction
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module int_div_dpath (
  input  logic                    clk,
  input  logic                    reset,
  input  imuldiv_pkg::muldiv_fn_e req_fn,
  input  imuldiv_pkg::operand_t   req_a,
  input  imuldiv_pkg::operand_t   req_b,
  input  logic                    a_en,
  input  logic                    b_en,
  input  logic                    a_mux_sel,
  input  logic                    sign_en,
  output imuldiv_pkg::result_t    resp_result
);
  import imuldiv_pkg::*;

  // upper 33 bits partial remainder, lower 32 bits dividend/quotient
  logic [2*xlen:0] rq_reg;
  operand_t        divisor_reg;

  // captured at load
  muldiv_fn_e fn_reg;
  logic       sign_a_reg;
  logic       sign_b_reg;

  logic            load_signed;
  operand_t        abs_a;
  operand_t        abs_b;
  logic [2*xlen:0] rq_load;
  logic [2*xlen:0] rq_shift;
  logic [xlen:0]   diff;
  logic [2*xlen:0] rq_step;
  operand_t        rem;
  operand_t        quo;
  operand_t        rem_fix;
  operand_t        quo_fix;
  logic            is_signed;

  // signed divide works on magnitudes
  assign load_signed = (req_fn == fn_div);
  assign abs_a = (load_signed && req_a[xlen-1]) ? -req_a : req_a;
  assign abs_b = (load_signed && req_b[xlen-1]) ? -req_b : req_b;
  assign rq_load = {{(xlen+1){1'b0}}, abs_a};

  // ---------------------------------------------------------------
  // restoring step
  // ---------------------------------------------------------------
  assign rq_shift = {rq_reg[2*xlen-1:0], 1'b0};
  assign diff     = rq_shift[2*xlen:xlen] - {1'b0, divisor_reg};

  // negative difference restores, otherwise keep it and set quotient bit
  assign rq_step = diff[xlen] ? rq_shift : {diff, rq_shift[xlen-1:1], 1'b1};

  // ---------------------------------------------------------------
  // sign correction
  // ---------------------------------------------------------------
  assign rem       = rq_reg[2*xlen-1:xlen];
  assign quo       = rq_reg[xlen-1:0];
  assign is_signed = (fn_reg == fn_div);

  // quotient negative on differing signs, remainder follows the dividend
  assign quo_fix = (is_signed && (sign_a_reg ^ sign_b_reg)) ? -quo : quo;
  assign rem_fix = (is_signed && sign_a_reg) ? -rem : rem;

  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_reg <= a_mux_sel ? rq_step : rq_load;
    end else if (sign_en) begin
      rq_reg <= {1'b0, rem_fix, quo_fix};
    end
    if (b_en) begin
      divisor_reg <= abs_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= fn_divu;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (b_en) begin
      fn_reg     <= req_fn;
      sign_a_reg <= req_a[xlen-1];
      sign_b_reg <= req_b[xlen-1];
    end
  end

  assign resp_result = {rem, quo};

endmodule

// File: int_div/int_div_iterative.sv
// ----------------------------------------------------------------------
// iterative restoring divider, control part joined with the datapath
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module int_div_iterative (
  input  logic                 clk,
  input  logic                 reset,
  muldiv_req_if.unit           req,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output imuldiv_pkg::result_t resp_result
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sign_en;

  int_div_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req.val),
    .req_rdy   (req.rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .sign_en   (sign_en)
  );

  int_div_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req.fn),
    .req_a       (req.a),
    .req_b       (req.b),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sign_en     (sign_en),
    .resp_result (resp_result)
  );

endmodule

// File: src/int_mul_iterative.sv
// ----------------------------------------------------------------------
// iterative shift-add signed multiplier with its own FSM
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module int_mul_iterative (
  input  logic                 clk,
  input  logic                 reset,
  muldiv_req_if.unit           req,
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output imuldiv_pkg::result_t resp_result
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_sign,
    st_done
  } state_e;

  localparam step_count_t last_step = step_count_t'(xlen - 1);

  state_e      state;
  state_e      state_next;
  step_count_t count;
  logic        accept;

  // accumulator, shifting multiplicand and multiplier
  result_t  acc;
  result_t  mcand;
  operand_t mplr;
  logic     neg;
  operand_t abs_a;
  operand_t abs_b;

  assign accept = req.val && req.rdy;
  assign abs_a  = req.a[xlen-1] ? -req.a : req.a;
  assign abs_b  = req.b[xlen-1] ? -req.b : req.b;

  // ---------------------------------------------------------------
  // control
  // ---------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (accept) state_next = st_calc;
      st_calc: if (count == last_step) state_next = st_sign;
      st_sign: state_next = st_done;
      st_done: if (resp_rdy) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      state <= state_next;
      count <= (state == st_calc) ? count + step_count_t'(1) : '0;
    end
  end

  // ---------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      acc   <= '0;
      mcand <= {{xlen{1'b0}}, abs_a};
      mplr  <= abs_b;
      neg   <= req.a[xlen-1] ^ req.b[xlen-1];
    end else if (state == st_calc) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplr[0]) begin
        acc <= acc + mcand;
      end
      mcand <= mcand << 1;
      mplr  <= mplr >> 1;
    end else if (state == st_sign && neg) begin
      acc <= -acc;
    end
  end

  assign req.rdy     = (state == st_idle);
  assign resp_val    = (state == st_done);
  assign resp_result = acc;

endmodule

// File: src/muldiv_resp_merge.sv
// ----------------------------------------------------------------------
// output side: order queue and in-order response forwarding
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module muldiv_resp_merge #(
  parameter int order_depth = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   order_push,
  input  imuldiv_pkg::unit_sel_e order_unit,
  output logic                   order_full,
  input  logic                   mul_resp_val,
  output logic                   mul_resp_rdy,
  input  imuldiv_pkg::result_t   mul_resp_result,
  input  logic                   div_resp_val,
  output logic                   div_resp_rdy,
  input  imuldiv_pkg::result_t   div_resp_result,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  output imuldiv_pkg::result_t   resp_result
);
  import imuldiv_pkg::*;

  localparam int addr_w = $clog2(order_depth);

  unit_sel_e       order_mem [order_depth];
  // extra msb tells full from empty
  logic [addr_w:0] wr_ptr;
  logic [addr_w:0] rd_ptr;
  logic            empty;
  logic            pop;
  unit_sel_e       head;

  assign empty = (wr_ptr == rd_ptr);
  assign order_full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                      (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
  assign head = order_mem[rd_ptr[addr_w-1:0]];

  // forward only the unit at the head; the other one waits
  assign resp_val = !empty &&
                    ((head == unit_mul) ? mul_resp_val : div_resp_val);
  assign resp_result = (head == unit_mul) ? mul_resp_result : div_resp_result;
  assign mul_resp_rdy = !empty && (head == unit_mul) && resp_rdy;
  assign div_resp_rdy = !empty && (head == unit_div) && resp_rdy;

  assign pop = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (order_push) begin
      order_mem[wr_ptr[addr_w-1:0]] <= order_unit;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (order_push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// File: src/imuldiv_top.sv
// ----------------------------------------------------------------------
// multiply/divide unit top level, request steer, both units, merge
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module imuldiv_top #(
  parameter int order_depth = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  imuldiv_pkg::muldiv_fn_e req_fn,
  input  imuldiv_pkg::operand_t   req_a,
  input  imuldiv_pkg::operand_t   req_b,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output imuldiv_pkg::result_t    resp_result
);
  import imuldiv_pkg::*;

  muldiv_req_if mul_req ();
  muldiv_req_if div_req ();

  // order path
  logic      order_push;
  unit_sel_e order_unit;
  logic      order_full;

  // unit responses
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t mul_resp_result;
  logic    div_resp_val;
  logic    div_resp_rdy;
  result_t div_resp_result;

  muldiv_req_steer u_steer (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .req_fn     (req_fn),
    .req_a      (req_a),
    .req_b      (req_b),
    .mul_req    (mul_req),
    .div_req    (div_req),
    .order_push (order_push),
    .order_unit (order_unit),
    .order_full (order_full)
  );

  int_mul_iterative u_mul (
    .clk         (clk),
    .reset       (reset),
    .req         (mul_req),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

  int_div_iterative u_div (
    .clk         (clk),
    .reset       (reset),
    .req         (div_req),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_result)
  );

  muldiv_resp_merge #(
    .order_depth (order_depth)
  ) u_merge (
    .clk             (clk),
    .reset           (reset),
    .order_push      (order_push),
    .order_unit      (order_unit),
    .order_full      (order_full),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_rdy    (mul_resp_rdy),
    .mul_resp_result (mul_resp_result),
    .div_resp_val    (div_resp_val),
    .div_resp_rdy    (div_resp_rdy),
    .div_resp_result (div_resp_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .resp_result     (resp_result)
  );

endmodule

// File: tests/imuldiv_checker.sv
// ----------------------------------------------------------------------
// response port assertions, bound to the multiply/divide top level
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module imuldiv_checker (
  input logic                 clk,
  input logic                 reset,
  input logic                 req_val,
  input logic                 req_rdy,
  input logic                 resp_val,
  input logic                 resp_rdy,
  input imuldiv_pkg::result_t resp_result
);

  // requests accepted but not yet answered
  int outstanding;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(req_val && req_rdy) - int'(resp_val && resp_rdy);
    end
  end

  // a stalled response keeps val and its value
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else $error("response dropped or changed while resp_rdy was low");

  // empty order queue after reset
  resp_idle_after_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

  resp_has_request: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> outstanding > 0)
    else $error("response left without an earlier accepted request");

endmodule

bind imuldiv_top imuldiv_checker u_checker (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

// File: tests/imuldiv_tb.sv
// ----------------------------------------------------------------------
// testbench of the multiply/divide unit: clock, reset, stimulus table,
// result model, in-order response checks under random back-pressure
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module imuldiv_tb;
  import imuldiv_pkg::*;

  // longest wait for any handshake, in cycles
  localparam int timeout_cycles = 500;

  // one table row, expected result filled in from the model
  typedef struct packed {
    muldiv_fn_e fn;
    operand_t   a;
    operand_t   b;
    result_t    expected;
  } stim_t;

  logic       clk;
  logic       reset;
  logic       req_val;
  logic       req_rdy;
  muldiv_fn_e req_fn;
  operand_t   req_a;
  operand_t   req_b;
  logic       resp_val;
  logic       resp_rdy;
  result_t    resp_result;

  stim_t   stim_table [$];
  // results of accepted requests, oldest first
  result_t expected_q [$];
  integer  seed = 32'h7e2d;

  imuldiv_top #(
    .order_depth (4)
  ) u_imuldiv_top (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ----------------------------------------------------------------------
  // result model and stimulus table
  // ----------------------------------------------------------------------
  function automatic result_t expected_result(muldiv_fn_e fn, operand_t a, operand_t b);
    int       sa;
    int       sb;
    longint   prod;
    operand_t q;
    operand_t r;
    sa = a;
    sb = b;
    if (fn == fn_mul) begin
      // full signed product
      prod = longint'(sa) * longint'(sb);
      return prod;
    end
    if (fn == fn_divu) begin
      q = a / b;
      r = a % b;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // overflow case wraps to the most negative quotient
      q = 32'h8000_0000;
      r = '0;
    end else begin
      // truncating divide, remainder follows the dividend
      q = sa / sb;
      r = sa % sb;
    end
    return {r, q};
  endfunction

  task automatic add_entry(muldiv_fn_e fn, operand_t a, operand_t b);
    stim_t entry;
    entry.fn       = fn;
    entry.a        = a;
    entry.b        = b;
    entry.expected = expected_result(fn, a, b);
    stim_table.push_back(entry);
  endtask

  // mixed on purpose so both units overlap and order matters
  task automatic build_table();
    add_entry(fn_divu, 32'd100, 32'd7);
    add_entry(fn_mul, 32'd3, 32'd5);
    add_entry(fn_divu, 32'hffff_ffff, 32'd1);
    add_entry(fn_mul, -32'sd3, 32'd5);
    add_entry(fn_divu, 32'h8000_0000, 32'd3);
    add_entry(fn_mul, 32'd3, -32'sd5);
    add_entry(fn_divu, 32'hffff_ffff, 32'hffff_fffe);
    add_entry(fn_mul, -32'sd3, -32'sd5);
    add_entry(fn_divu, 32'd5, 32'd9);
    add_entry(fn_divu, 32'hdead_beef, 32'h0000_1234);
    add_entry(fn_div, 32'd100, 32'd7);
    add_entry(fn_div, -32'sd100, 32'd7);
    add_entry(fn_div, 32'd100, -32'sd7);
    add_entry(fn_div, -32'sd100, -32'sd7);
    add_entry(fn_mul, 32'd0, 32'h8765_4321);
    add_entry(fn_div, 32'h8000_0000, 32'hffff_ffff);
    add_entry(fn_mul, 32'h7fff_ffff, 32'h7fff_ffff);
    add_entry(fn_mul, 32'h8000_0000, 32'h8000_0000);
    add_entry(fn_div, 32'h8000_0000, 32'd1);
    add_entry(fn_mul, 32'h8000_0000, 32'h7fff_ffff);
    add_entry(fn_mul, 32'h8000_0000, 32'hffff_ffff);
    add_entry(fn_div, -32'sd1, 32'd2);
    add_entry(fn_mul, 32'h1234_5678, -32'sd1);
    add_entry(fn_div, 32'h7fff_ffff, -32'sd2);
  endtask

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic report_failure(string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic compare_result(string name, result_t got, result_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ----------------------------------------------------------------------
  // request driver and response receiver
  // ----------------------------------------------------------------------
  task automatic drive_requests();
    int wait_cycles;
    foreach (stim_table[i]) begin
      @(posedge clk);
      req_val <= 1'b1;
      req_fn  <= stim_table[i].fn;
      req_a   <= stim_table[i].a;
      req_b   <= stim_table[i].b;
      wait_cycles = 0;
      @(negedge clk);
      while (!req_rdy) begin
        wait_cycles++;
        if (wait_cycles > timeout_cycles) begin
          report_failure("timeout: req_rdy never came back for a pending request");
        end
        @(negedge clk);
      end
      // transfer on the coming rising edge
      expected_q.push_back(stim_table[i].expected);
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  task automatic collect_responses();
    int      idle_cycles;
    int      received;
    result_t expected;
    idle_cycles = 0;
    received    = 0;
    while (received < stim_table.size()) begin
      @(posedge clk);
      // roughly one cycle in four stalled
      resp_rdy <= (($random(seed) & 3) != 0);
      @(negedge clk);
      if (resp_val && resp_rdy) begin
        if (expected_q.size() == 0) begin
          report_failure("a response came out with no request outstanding");
        end
        expected = expected_q.pop_front();
        compare_result("resp_result", resp_result, expected);
        received++;
        idle_cycles = 0;
      end else begin
        idle_cycles++;
        if (idle_cycles > timeout_cycles) begin
          report_failure("timeout: no response arrived for an accepted request");
        end
      end
    end
    @(posedge clk);
    resp_rdy <= 1'b1;
  endtask

  // nothing may follow the last response
  task automatic check_quiet();
    repeat (50) begin
      @(negedge clk);
      compare_bit("resp_val", resp_val, 1'b0);
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = fn_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // idle right after reset
    @(negedge clk);
    compare_bit("resp_val", resp_val, 1'b0);
    compare_bit("req_rdy", req_rdy, 1'b1);
    fork
      drive_requests();
      collect_responses();
    join
    check_quiet();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: compile.f
common/imuldiv_pkg.sv
common/muldiv_req_if.sv
src/muldiv_req_steer.sv
int_div/int_div_ctrl.sv
int_div/int_div_dpath.sv
int_div/int_div_iterative.sv
src/int_mul_iterative.sv
src/muldiv_resp_merge.sv
src/imuldiv_top.sv
tests/imuldiv_checker.sv
tests/imuldiv_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and search the output for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --assert --timing -Wno-fatal --top-module imuldiv_tb \
    -f compile.f -o imuldiv_sim &&
  ./obj_dir/imuldiv_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
  echo "run.sh: test passed" ||
  { echo "run.sh: test failed"; exit 1; }
